/* verilog/cp0Pkg.sv */
package cp0Pkg;

	// ****************************************
	// register addresses and exception codes
	// ****************************************

	typedef logic [4:0] cp0Addr;
	typedef logic [4:0] excCode;

	localparam cp0Addr addrCount = 5'd9;
	localparam cp0Addr addrCompare = 5'd11;
	localparam cp0Addr addrStatus = 5'd12;
	localparam cp0Addr addrCause = 5'd13;
	localparam cp0Addr addrEpc = 5'd14;
	localparam cp0Addr addrPrid = 5'd15;

	localparam excCode excInterrupt = 5'd0;
	localparam excCode excAddrLoad = 5'd4;
	localparam excCode excAddrStore = 5'd5;
	localparam excCode excReserved = 5'd10;
	localparam excCode excOverflow = 5'd12;

	// ****************************************
	// status and cause layouts
	// ****************************************

	typedef struct packed {
		logic [15:0] unusedHigh;
		logic [5:0] interruptMask;
		logic [7:0] unusedLow;
		logic exceptionLevel;
		logic interruptEnable;
	} statusFields;

	// software moves the raw word, the trap logic reads the fields
	typedef union packed {
		logic [31:0] raw;
		statusFields fields;
	} statusWord;

	typedef struct packed {
		logic branchDelay;
		logic [14:0] zeroHigh;
		logic [5:0] interruptPending;
		logic [2:0] zeroMid;
		excCode code;
		logic [1:0] zeroLow;
	} causeFields;

	// all six lines unmasked, interrupts enabled, not in a handler
	localparam logic [31:0] statusResetValue = 32'h0000fc01;

	typedef struct packed {
		logic take;
		causeFields cause;
		logic [31:0] epc;
	} trapUpdate;

	typedef struct packed {
		logic enable;
		cp0Addr address;
		logic [31:0] data;
	} cp0Write;

endpackage

/* verilog/exceptionControl.sv */
`timescale 1ns/100ps

module exceptionControl import cp0Pkg::*; (
	input logic clk,
	input logic reset,
	input statusWord status,
	input cp0Write write,
	input logic [31:0] pc,
	input logic inBranchDelay,
	input excCode errorCode,
	input logic [5:0] interruptRequest,
	input logic timerInterrupt,
	input logic exceptionReturn,
	output logic trapTaken,
	output trapUpdate update,
	output logic exceptionLevel
);

	typedef enum logic {
		running,
		inHandler
	} handlerState;

	handlerState state;
	handlerState nextState;
	logic [5:0] requests;
	logic errorTrap;
	logic interruptTrap;
	logic statusWrite;
	statusWord written;
	logic [31:0] alignedPc;

	// the timer shares line 5 with the external request
	assign requests = {interruptRequest[5] | timerInterrupt, interruptRequest[4:0]};

	always_comb begin
		case (errorCode)
			excAddrLoad, excAddrStore, excReserved, excOverflow: errorTrap = 1'b1;
			default: errorTrap = 1'b0;
		endcase
	end

	assign interruptTrap = (|(requests & status.fields.interruptMask))
		&& status.fields.interruptEnable && (state == running);
	assign trapTaken = errorTrap || interruptTrap;

	// ****************************************
	// exception level state
	// ****************************************

	assign statusWrite = write.enable && (write.address == addrStatus);
	assign written = write.data;

	always_comb begin
		nextState = state;
		if (trapTaken) begin
			nextState = inHandler;
		end else if (exceptionReturn) begin
			nextState = running;
		end else if (statusWrite) begin
			nextState = written.fields.exceptionLevel ? inHandler : running;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= running;
		else
			state <= nextState;
	end

	assign exceptionLevel = (state == inHandler);

	// ****************************************
	// new cause and EPC
	// ****************************************

	assign alignedPc = {pc[31:2], 2'b00};

	// a trap in a delay slot restarts at the branch before it
	always_comb begin
		update.take = trapTaken;
		update.cause.branchDelay = inBranchDelay;
		update.cause.zeroHigh = '0;
		update.cause.interruptPending = requests;
		update.cause.zeroMid = '0;
		update.cause.code = interruptTrap ? excInterrupt : errorCode;
		update.cause.zeroLow = '0;
		update.epc = inBranchDelay ? alignedPc - 32'd4 : alignedPc;
	end

endmodule

/* verilog/cp0Timer.sv */
`timescale 1ns/100ps

module cp0Timer import cp0Pkg::*; (
	input logic clk,
	input logic reset,
	input cp0Write write,
	output logic [31:0] count,
	output logic [31:0] compare,
	output logic timerInterrupt
);

	logic countWrite;
	logic compareWrite;
	logic armed;

	assign countWrite = write.enable && (write.address == addrCount);
	assign compareWrite = write.enable && (write.address == addrCompare);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (countWrite) begin
			count <= write.data;
		end else begin
			count <= count + 32'd1;
		end
	end

	// the match only counts once compare has been written, so count and
	// compare both sitting at zero out of reset never fire the timer
	always_ff @(posedge clk) begin
		if (reset) begin
			compare <= '0;
			armed <= 1'b0;
			timerInterrupt <= 1'b0;
		end else if (compareWrite) begin
			compare <= write.data;
			armed <= 1'b1;
			timerInterrupt <= 1'b0;
		end else if (armed && (count == compare)) begin
			armed <= 1'b0;
			timerInterrupt <= 1'b1;
		end
	end

endmodule

/* verilog/cp0RegisterFile.sv */
`timescale 1ns/100ps

module cp0RegisterFile import cp0Pkg::*; #(
	parameter logic [31:0] processorIdReset = 32'h0125e591
) (
	input logic clk,
	input logic reset,
	input cp0Write write,
	input trapUpdate update,
	input logic exceptionLevel,
	input logic [31:0] count,
	input logic [31:0] compare,
	input logic [5:0] interruptPending,
	input cp0Addr readAddress,
	output logic [31:0] readData,
	output statusWord status,
	output logic [31:0] returnAddress
);

	statusWord statusReg;
	causeFields causeReg;
	logic [31:0] epcReg;
	logic [31:0] processorId;
	logic [31:0] storedData;
	logic epcWrite;

	// ****************************************
	// registers
	// ****************************************

	// a trap drops any move-to in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			statusReg <= statusResetValue;
			causeReg <= '0;
			epcReg <= '0;
			processorId <= processorIdReset;
		end else if (update.take) begin
			causeReg <= update.cause;
			epcReg <= update.epc;
		end else begin
			causeReg.interruptPending <= interruptPending;
			if (write.enable) begin
				case (write.address)
					addrStatus: statusReg <= write.data;
					addrCause: causeReg <= write.data;
					addrEpc: epcReg <= write.data;
					addrPrid: processorId <= write.data;
					default: ;
				endcase
			end
		end
	end

	// bit 1 is owned by the exception control state, not by this register
	always_comb begin
		status = statusReg;
		status.fields.exceptionLevel = exceptionLevel;
	end

	// ****************************************
	// read port
	// ****************************************

	always_comb begin
		case (readAddress)
			addrCount: storedData = count;
			addrCompare: storedData = compare;
			addrStatus: storedData = status.raw;
			addrCause: storedData = causeReg;
			addrEpc: storedData = epcReg;
			addrPrid: storedData = processorId;
			default: storedData = '0;
		endcase
	end

	// a move-to shows its own data in the cycle it is issued
	assign readData = write.enable ? write.data : storedData;

	assign epcWrite = write.enable && (write.address == addrEpc);
	assign returnAddress = epcWrite ? write.data : epcReg;

endmodule

/* verilog/coprocessor0.sv */
`timescale 1ns/100ps

module coprocessor0 import cp0Pkg::*; #(
	parameter logic [31:0] processorIdReset = 32'h0125e591
) (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input cp0Addr address,
	input logic [31:0] writeData,
	input logic [31:0] pc,
	input logic inBranchDelay,
	input excCode errorCode,
	input logic [5:0] interruptRequest,
	input logic exceptionReturn,
	output logic [31:0] readData,
	output logic [31:0] returnAddress,
	output logic trapTaken
);

	cp0Write writeBus;
	trapUpdate trapInfo;
	statusWord status;
	logic exceptionLevel;
	logic [31:0] count;
	logic [31:0] compare;
	logic timerInterrupt;

	assign writeBus = '{enable: writeEnable, address: address, data: writeData};

	exceptionControl control_i (
		.clk(clk),
		.reset(reset),
		.status(status),
		.write(writeBus),
		.pc(pc),
		.inBranchDelay(inBranchDelay),
		.errorCode(errorCode),
		.interruptRequest(interruptRequest),
		.timerInterrupt(timerInterrupt),
		.exceptionReturn(exceptionReturn),
		.trapTaken(trapTaken),
		.update(trapInfo),
		.exceptionLevel(exceptionLevel)
	);

	cp0Timer timer_i (
		.clk(clk),
		.reset(reset),
		.write(writeBus),
		.count(count),
		.compare(compare),
		.timerInterrupt(timerInterrupt)
	);

	// the pending field tracks the combined requests formed by the control block
	cp0RegisterFile #(
		.processorIdReset(processorIdReset)
	) registers_i (
		.clk(clk),
		.reset(reset),
		.write(writeBus),
		.update(trapInfo),
		.exceptionLevel(exceptionLevel),
		.count(count),
		.compare(compare),
		.interruptPending(trapInfo.cause.interruptPending),
		.readAddress(address),
		.readData(readData),
		.status(status),
		.returnAddress(returnAddress)
	);

endmodule

/* tb/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// release on a falling edge, away from the DUT's sampling edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* tb/coprocessor0_assertions.sv */
`timescale 1ns/100ps

module coprocessor0Assertions import cp0Pkg::*; (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input cp0Addr address,
	input logic [31:0] pc,
	input logic inBranchDelay,
	input excCode errorCode,
	input logic [5:0] interruptRequest,
	input logic timerInterrupt,
	input logic exceptionLevel,
	input statusWord status,
	input logic [31:0] readData,
	input logic [31:0] returnAddress,
	input logic trapTaken
);

	int failureCount = 0;
	logic [5:0] requests;
	logic errorTrap;
	logic interruptTrap;
	logic [31:0] expectedEpc;
	logic [31:0] expectedCause;

	assign requests = {interruptRequest[5] | timerInterrupt, interruptRequest[4:0]};
	assign errorTrap = errorCode inside {5'd4, 5'd5, 5'd10, 5'd12};
	assign interruptTrap = (|(requests & status.raw[15:10])) && status.raw[0]
		&& !exceptionLevel;
	assign expectedEpc = {pc[31:2], 2'b00} - (inBranchDelay ? 32'd4 : 32'd0);
	assign expectedCause = {inBranchDelay, 15'd0, requests, 3'd0,
		interruptTrap ? 5'd0 : errorCode, 2'd0};

	// ****************************************
	// trap effects
	// ****************************************

	epcLoaded: assert property (@(posedge clk) disable iff (reset)
		trapTaken |=> (writeEnable && address == addrEpc)
			|| returnAddress == $past(expectedEpc))
	else begin
		failureCount++;
		$error("FAILED returnAddress: got %h, expected %h", $sampled(returnAddress),
			$past(expectedEpc));
	end

	// only checked when the cycle after the trap reads cause
	causeLoaded: assert property (@(posedge clk) disable iff (reset)
		trapTaken |=> writeEnable || address != addrCause
			|| readData == $past(expectedCause))
	else begin
		failureCount++;
		$error("FAILED readData: got %h, expected %h", $sampled(readData),
			$past(expectedCause));
	end

	maskedInHandler: assert property (@(posedge clk) disable iff (reset)
		exceptionLevel && !errorTrap |-> !trapTaken)
	else begin
		failureCount++;
		$error("interrupt trap taken while exception level is set");
	end

	// the move-to status in a trap cycle is dropped and the level still rises
	trapBeatsWrite: assert property (@(posedge clk) disable iff (reset)
		trapTaken && writeEnable && address == addrStatus |=> exceptionLevel
			&& (status.raw & 32'hffff_fffd) == $past(status.raw & 32'hffff_fffd))
	else begin
		failureCount++;
		$error("status write in a trap cycle was not dropped");
	end

endmodule

bind coprocessor0 coprocessor0Assertions assertions_i (.*);

/* tb/coprocessor0Tb.sv */
`timescale 1ns/100ps

module coprocessor0Tb import cp0Pkg::*; ();

	localparam int cycleLimit = 2000;

	logic clk;
	logic reset;
	logic writeEnable;
	cp0Addr address;
	logic [31:0] writeData;
	logic [31:0] pc;
	logic inBranchDelay;
	excCode errorCode;
	logic [5:0] interruptRequest;
	logic exceptionReturn;
	logic [31:0] readData;
	logic [31:0] returnAddress;
	logic trapTaken;
	logic [5:0] heldRequest;
	int cycles;
	int checks;
	int errors;
	int errorsAtStart;
	int testsRun;

	clockGen clock_i (.clk(clk), .reset(reset));

	coprocessor0 dut_i (
		.clk(clk),
		.reset(reset),
		.writeEnable(writeEnable),
		.address(address),
		.writeData(writeData),
		.pc(pc),
		.inBranchDelay(inBranchDelay),
		.errorCode(errorCode),
		.interruptRequest(interruptRequest),
		.exceptionReturn(exceptionReturn),
		.readData(readData),
		.returnAddress(returnAddress),
		.trapTaken(trapTaken)
	);

	// ****************************************
	// helpers
	// ****************************************

	task automatic driveIdle();
		writeEnable = 1'b0;
		address = '0;
		writeData = '0;
		pc = '0;
		inBranchDelay = 1'b0;
		errorCode = '0;
		interruptRequest = heldRequest;
		exceptionReturn = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic checkTrue(input logic condition, input string what);
		checks++;
		if (!condition) begin
			errors++;
			$display("error: %s", what);
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors == errorsAtStart)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d errors", name, errors - errorsAtStart);
		errorsAtStart = errors;
	endtask

	// every step drives on the falling edge and samples halfway through the low phase
	task automatic idleCycle();
		@(negedge clk);
		driveIdle();
		#5;
	endtask

	task automatic readReg(input cp0Addr addr, output logic [31:0] value);
		@(negedge clk);
		driveIdle();
		address = addr;
		#5;
		value = readData;
	endtask

	task automatic writeReg(input cp0Addr addr, input logic [31:0] data);
		@(negedge clk);
		driveIdle();
		writeEnable = 1'b1;
		address = addr;
		writeData = data;
		#5;
		checkValue("readData", readData, data);
		if (addr == addrEpc)
			checkValue("returnAddress", returnAddress, data);
	endtask

	task automatic pulseReturn();
		@(negedge clk);
		driveIdle();
		exceptionReturn = 1'b1;
		#5;
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("Finished with errors");
		$finish;
	end

	// ****************************************
	// tests
	// ****************************************

	initial begin
		cp0Addr regList[5];
		excCode trapCodes[4];
		logic [31:0] value;
		logic [31:0] data;
		logic branch;
		logic found;
		int i;
		heldRequest = '0;
		driveIdle();
		void'($urandom(42694));
		regList = '{addrStatus, addrCause, addrEpc, addrPrid, addrCompare};
		trapCodes = '{5'd4, 5'd5, 5'd10, 5'd12};
		wait (!reset);

		readReg(addrStatus, value);
		checkValue("status", value, 32'h0000fc01);
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd0);
		readReg(addrPrid, value);
		checkValue("prid", value, 32'h0125e591);
		readReg(addrCause, value);
		checkValue("cause", value, 32'd0);
		readReg(addrEpc, value);
		checkValue("epc", value, 32'd0);
		readReg(addrCompare, value);
		checkValue("compare", value, 32'd0);
		finishTest("reset");

		for (i = 0; i < 5; i++) begin
			data = $urandom();
			writeReg(regList[i], data);
			readReg(regList[i], value);
			checkValue("readData", value, data);
		end
		writeReg(addrStatus, 32'h00000002);
		readReg(addrStatus, value);
		checkValue("status", value, 32'h00000002);
		writeReg(addrStatus, 32'h00000000);
		readReg(addrStatus, value);
		checkValue("status", value, 32'h00000000);
		finishTest("software writes");

		writeReg(addrStatus, 32'h0000fc01);
		for (i = 0; i < 8; i++) begin
			branch = i[0];
			data = $urandom();
			@(negedge clk);
			driveIdle();
			pc = data;
			inBranchDelay = branch;
			errorCode = trapCodes[i / 2];
			// the move-to status of zero in the delay-slot cases must be lost
			writeEnable = branch;
			address = addrStatus;
			#5;
			checkValue("trapTaken", {31'd0, trapTaken}, 32'd1);
			readReg(addrCause, value);
			checkValue("cause", value, {branch, 15'd0, 6'd0, 3'd0, trapCodes[i / 2], 2'd0});
			checkValue("returnAddress", returnAddress,
				{data[31:2], 2'b00} - (branch ? 32'd4 : 32'd0));
			readReg(addrStatus, value);
			checkValue("status", value, 32'h0000fc03);
			pulseReturn();
		end
		for (i = 0; i < 32; i++) begin
			@(negedge clk);
			driveIdle();
			errorCode = i[4:0];
			#5;
			checkValue("trapTaken", {31'd0, trapTaken},
				{31'd0, (i == 4 || i == 5 || i == 10 || i == 12)});
		end
		pulseReturn();
		readReg(addrStatus, value);
		checkValue("status", value, 32'h0000fc01);
		finishTest("error traps");

		// only line 2 is unmasked
		writeReg(addrStatus, 32'h00001001);
		heldRequest = 6'b000010;
		idleCycle();
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd0);
		heldRequest = 6'b000100;
		idleCycle();
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd1);
		readReg(addrCause, value);
		checkValue("cause", value, 32'h00001000);
		readReg(addrStatus, value);
		checkValue("status", value, 32'h00001003);
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd0);
		pulseReturn();
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd0);
		idleCycle();
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd1);
		heldRequest = '0;
		pulseReturn();
		writeReg(addrStatus, 32'h00001000);
		heldRequest = 6'b000100;
		idleCycle();
		checkValue("trapTaken", {31'd0, trapTaken}, 32'd0);
		heldRequest = '0;
		finishTest("interrupt masking");

		writeReg(addrStatus, 32'h00000000);
		writeReg(addrCount, 32'd0);
		writeReg(addrCompare, 32'd30);
		found = 1'b0;
		for (i = 0; i < 40 && !found; i++) begin
			readReg(addrCause, value);
			found = value[15];
		end
		checkTrue(found, "timer interrupt did not reach cause bit 15 within 40 cycles");
		repeat (3) begin
			readReg(addrCause, value);
			checkValue("cause[15]", {31'd0, value[15]}, 32'd1);
		end
		writeReg(addrCompare, 32'hffffffff);
		idleCycle();
		readReg(addrCause, value);
		checkValue("cause[15]", {31'd0, value[15]}, 32'd0);
		writeReg(addrCount, 32'd0);
		writeReg(addrCompare, 32'd10);
		writeReg(addrStatus, 32'h00008001);
		found = 1'b0;
		for (i = 0; i < 40 && !found; i++) begin
			idleCycle();
			found = trapTaken;
		end
		checkTrue(found, "timer interrupt with line 5 unmasked never raised trapTaken");
		idleCycle();
		finishTest("timer");

		errors += dut_i.assertions_i.failureCount;
		$display("tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* files.f */
verilog/cp0Pkg.sv
verilog/exceptionControl.sv
verilog/cp0Timer.sv
verilog/cp0RegisterFile.sv
verilog/coprocessor0.sv
tb/clockGen.sv
tb/coprocessor0_assertions.sv
tb/coprocessor0Tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the CP0 testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

top=coprocessor0Tb
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module "$top" -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
"./obj_dir/V$top" +verilator+error+limit+100 > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with errors" "$logFile"; then
	echo "simulation reported errors"
	exit 1
fi
if ! grep -qx "Finished with no errors" "$logFile"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
exit 0
